/* verilog/hal_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, reset defaults and encodings
// Host opcodes and window calculator states
//////////////////////////////////////////////////

package hal_pkg;

	//////////////////////////////////////////////////
	// Widths

	// Pixel and line dimensions
	localparam int DIM_W = 12;

	// Host data word
	localparam int DATA_W = 16;

	// Sync duration counters
	localparam int SYNC_CNT_W = 16;

	//////////////////////////////////////////////////
	// Defaults

	// 1920x1080 until the host sends timing
	localparam logic [DIM_W-1:0] DEF_WIDTH  = 12'd1920;
	localparam logic [DIM_W-1:0] DEF_HEIGHT = 12'd1080;

	// Data words carried by the timing command
	localparam int TIMING_WORDS = 8;

	//////////////////////////////////////////////////
	// Encodings

	// Kept host opcodes, CMD_NONE while nothing is latched
	typedef enum logic [7:0] {
		CMD_NONE   = 8'h00,
		CMD_TIMING = 8'h20,
		CMD_VSET   = 8'h27,
		CMD_HSET   = 8'h37,
		CMD_ASPECT = 8'h3A
	} host_cmd_e;

	// Window calculator sequence
	typedef enum logic [2:0] {
		WIN_IDLE,
		WIN_W_START,
		WIN_W_WAIT,
		WIN_H_START,
		WIN_H_WAIT,
		WIN_CLAMP,
		WIN_CENTRE
	} win_state_e;

endpackage

/* verilog/video_cfg_if.sv */
//////////////////////////////////////////////////
// Decoded video settings, decoder to window calc
//////////////////////////////////////////////////

interface video_cfg_if import hal_pkg::*; ();

	// Active frame size
	logic [DIM_W-1:0] width;
	logic [DIM_W-1:0] height;

	// Output limits, zero means none
	logic [DIM_W-1:0] hset;
	logic [DIM_W-1:0] vset;
	logic             freescale;

	// Aspect ratio, zero means none
	logic [DIM_W-1:0] arx;
	logic [DIM_W-1:0] ary;

	modport source (output width, height, hset, vset, freescale, arx, ary);

	modport sink (input width, height, hset, vset, freescale, arx, ary);

endinterface

/* verilog/host_cmd_decoder.sv */
//////////////////////////////////////////////////
// Host command decoder with delayed acknowledge
// Holds the video settings registers
//////////////////////////////////////////////////

module host_cmd_decoder import hal_pkg::*; (
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic              i_io_uio,
	input  logic              i_io_strobe,
	input  logic [DATA_W-1:0] i_io_din,
	output logic              o_io_ack,
	video_cfg_if.source       cfg
);

	logic      strobe_q1;
	logic      strobe_q2;
	logic      strobe_rise;
	logic      has_cmd;
	host_cmd_e cmd;
	logic [$clog2(TIMING_WORDS+1)-1:0] word_cnt;

	// Two-stage strobe delay doubles as the acknowledge
	assign strobe_rise = strobe_q1 & ~strobe_q2;
	assign o_io_ack    = strobe_q2;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			strobe_q1 <= 1'b0;
			strobe_q2 <= 1'b0;
		end else begin
			strobe_q1 <= i_io_strobe;
			strobe_q2 <= strobe_q1;
		end
	end

	//////////////////////////////////////////////////
	// Command and data words

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd       <= 1'b0;
			cmd           <= CMD_NONE;
			word_cnt      <= '0;
			cfg.width     <= DEF_WIDTH;
			cfg.height    <= DEF_HEIGHT;
			cfg.hset      <= '0;
			cfg.vset      <= '0;
			cfg.freescale <= 1'b0;
			cfg.arx       <= '0;
			cfg.ary       <= '0;
		end else if (!i_io_uio) begin
			// Select dropped so the next word is a new opcode
			has_cmd  <= 1'b0;
			cmd      <= CMD_NONE;
			word_cnt <= '0;
		end else if (strobe_rise) begin
			if (!has_cmd) begin
				has_cmd  <= 1'b1;
				cmd      <= host_cmd_e'(i_io_din[7:0]);
				word_cnt <= '0;
			end else begin
				if (word_cnt != '1)
					word_cnt <= word_cnt + 1'b1;
				case (cmd)
					CMD_TIMING: begin
						// Porches and sync words are counted but not stored
						if (word_cnt == 0)
							cfg.width <= i_io_din[DIM_W-1:0];
						if (word_cnt == 4)
							cfg.height <= i_io_din[DIM_W-1:0];
					end
					CMD_VSET: cfg.vset <= i_io_din[DIM_W-1:0];
					CMD_HSET: begin
						cfg.hset      <= i_io_din[DIM_W-1:0];
						cfg.freescale <= i_io_din[DATA_W-1];
					end
					CMD_ASPECT: begin
						if (word_cnt == 0)
							cfg.arx <= i_io_din[DIM_W-1:0];
						if (word_cnt == 1)
							cfg.ary <= i_io_din[DIM_W-1:0];
					end
					default: ;
				endcase
			end
		end
	end

	a_timing_cnt: assert property (@(posedge clk_sys) disable iff (resetd)
		(cmd == CMD_TIMING) |-> (word_cnt <= TIMING_WORDS))
		else $error("timing word counter past last word");

endmodule

/* verilog/umuldiv.sv */
//////////////////////////////////////////////////
// Sequential unsigned multiply then divide
//////////////////////////////////////////////////

module umuldiv import hal_pkg::*; (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_start,
	output logic             o_busy,
	input  logic [DIM_W-1:0] i_mul1,
	input  logic [DIM_W-1:0] i_mul2,
	input  logic [DIM_W-1:0] i_div,
	output logic [DIM_W-1:0] o_result
);

	logic [2*DIM_W-1:0]       prod;
	logic [DIM_W:0]           rem;
	logic [DIM_W:0]           rem_sh;
	logic [DIM_W-1:0]         quo;
	logic [DIM_W-1:0]         div_q;
	logic [$clog2(DIM_W)-1:0] step;
	logic                     busy;
	logic                     chk;
	logic                     ovf;

	assign prod     = i_mul1 * i_mul2;
	// Next dividend bit shifted into the partial remainder
	assign rem_sh   = {rem[DIM_W-1:0], quo[DIM_W-1]};
	assign o_busy   = busy;
	assign o_result = ovf ? '1 : quo;

	// First busy cycle checks overflow, then one quotient bit per cycle
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			busy <= 1'b0;
			chk  <= 1'b0;
			step <= '0;
		end else if (!busy) begin
			if (i_start) begin
				busy <= 1'b1;
				chk  <= 1'b1;
			end
		end else if (chk) begin
			chk  <= 1'b0;
			step <= ($clog2(DIM_W))'(DIM_W - 1);
		end else begin
			step <= step - 1'b1;
			if (step == '0)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!busy && i_start) begin
			rem   <= {1'b0, prod[2*DIM_W-1:DIM_W]};
			quo   <= prod[DIM_W-1:0];
			div_q <= i_div;
		end else if (busy && chk) begin
			// Quotient too wide for DIM_W bits, or divide by zero
			ovf <= (div_q == '0) || (rem[DIM_W-1:0] >= div_q);
		end else if (busy) begin
			if (rem_sh >= {1'b0, div_q}) begin
				rem <= rem_sh - {1'b0, div_q};
				quo <= {quo[DIM_W-2:0], 1'b1};
			end else begin
				rem <= rem_sh;
				quo <= {quo[DIM_W-2:0], 1'b0};
			end
		end
	end

	a_no_restart: assert property (@(posedge clk_sys) disable iff (resetd)
		o_busy |-> !i_start)
		else $error("start while division in progress");

endmodule

/* verilog/video_window_calc.sv */
//////////////////////////////////////////////////
// Output size limits and aspect correction
// Centred video window in the output frame
//////////////////////////////////////////////////

module video_window_calc import hal_pkg::*; (
	input  logic             clk_sys,
	input  logic             resetd,
	video_cfg_if.sink        cfg,
	output logic [DIM_W-1:0] o_hmin,
	output logic [DIM_W-1:0] o_hmax,
	output logic [DIM_W-1:0] o_vmin,
	output logic [DIM_W-1:0] o_vmax
);

	logic [DIM_W-1:0] out_w;
	logic [DIM_W-1:0] out_h;
	logic [DIM_W-1:0] wcalc;
	logic [DIM_W-1:0] hcalc;
	logic [DIM_W-1:0] win_w;
	logic [DIM_W-1:0] win_h;
	logic [DIM_W-1:0] h_off;
	logic [DIM_W-1:0] v_off;
	logic             md_start;
	logic             md_busy;
	logic [DIM_W-1:0] md_mul1;
	logic [DIM_W-1:0] md_mul2;
	logic [DIM_W-1:0] md_div;
	logic [DIM_W-1:0] md_res;
	win_state_e       state;

	umuldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.o_busy   (md_busy),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_result (md_res)
	);

	// Limit applies only when set and smaller than the frame
	always_ff @(posedge clk_sys) begin
		out_w <= (cfg.hset != '0 && cfg.hset < cfg.width) ? cfg.hset : cfg.width;
		out_h <= (cfg.vset != '0 && cfg.vset < cfg.height) ? cfg.vset : cfg.height;
	end

	assign h_off = (cfg.width - win_w) >> 1;
	assign v_off = (cfg.height - win_h) >> 1;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= WIN_IDLE;
			md_start <= 1'b0;
			o_hmin   <= '0;
			o_hmax   <= DEF_WIDTH - 1'b1;
			o_vmin   <= '0;
			o_vmax   <= DEF_HEIGHT - 1'b1;
		end else begin
			md_start <= 1'b0;
			case (state)
				WIN_IDLE: begin
					if (cfg.freescale || cfg.arx == '0 || cfg.ary == '0) begin
						wcalc <= out_w;
						hcalc <= out_h;
						state <= WIN_CLAMP;
					end else begin
						state <= WIN_W_START;
					end
				end
				WIN_W_START: begin
					md_mul1  <= out_h;
					md_mul2  <= cfg.arx;
					md_div   <= cfg.ary;
					md_start <= 1'b1;
					state    <= WIN_W_WAIT;
				end
				WIN_W_WAIT: begin
					if (!md_start && !md_busy) begin
						wcalc <= md_res;
						state <= WIN_H_START;
					end
				end
				WIN_H_START: begin
					md_mul1  <= out_w;
					md_mul2  <= cfg.ary;
					md_div   <= cfg.arx;
					md_start <= 1'b1;
					state    <= WIN_H_WAIT;
				end
				WIN_H_WAIT: begin
					if (!md_start && !md_busy) begin
						hcalc <= md_res;
						state <= WIN_CLAMP;
					end
				end
				WIN_CLAMP: begin
					win_w <= (wcalc > out_w) ? out_w : wcalc;
					win_h <= (hcalc > out_h) ? out_h : hcalc;
					state <= WIN_CENTRE;
				end
				WIN_CENTRE: begin
					o_hmin <= h_off;
					o_hmax <= h_off + win_w - 1'b1;
					o_vmin <= v_off;
					o_vmax <= v_off + win_h - 1'b1;
					state  <= WIN_IDLE;
				end
				default: state <= WIN_IDLE;
			endcase
		end
	end

	a_window_order: assert property (@(posedge clk_sys) disable iff (resetd)
		(o_hmin <= o_hmax) && (o_vmin <= o_vmax))
		else $error("window bounds inverted");

endmodule

/* verilog/sync_polarity_fix.sv */
//////////////////////////////////////////////////
// Sync polarity normaliser, active high out
//////////////////////////////////////////////////

module sync_polarity_fix import hal_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                  sync_q1;
	logic                  sync_q2;
	logic                  pol;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;

	// Longer high phase means the pulses are active low
	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_q1  <= 1'b0;
			sync_q2  <= 1'b0;
			pol      <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else begin
			sync_q1 <= i_sync;
			sync_q2 <= sync_q1;
			if (sync_q1 != sync_q2)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;
			if (sync_q1 & ~sync_q2)
				low_len <= cnt;
			if (~sync_q1 & sync_q2)
				high_len <= cnt;
			pol <= high_len > low_len;
		end
	end

endmodule

/* verilog/csync_gen.sv */
//////////////////////////////////////////////////
// Composite sync from normalised hsync and vsync
//////////////////////////////////////////////////

module csync_gen import hal_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	output logic o_csync
);

	logic                  hs_q;
	logic                  vs_q;
	logic                  hs_part;
	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;

	assign o_csync = vs_q ^ hs_part;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
			hs_part  <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			hs_q  <= i_hs;
			vs_q  <= i_vs;
			h_cnt <= h_cnt + 1'b1;

			// Counter restarts on both hsync edges
			if (hs_q != i_hs) begin
				h_cnt <= '0;
				if (i_hs)
					line_len <= h_cnt - hs_len;
				else
					hs_len <= h_cnt;
			end

			// Pulse moves one sync width ahead while vsync is active
			if (!i_vs)
				hs_part <= i_hs;
			else if (i_hs && !hs_q)
				hs_part <= 1'b0;
			else if (h_cnt == line_len)
				hs_part <= 1'b1;
		end
	end

endmodule

/* verilog/sys_hal_top.sv */
//////////////////////////////////////////////////
// Top level of the host and video timing block
//////////////////////////////////////////////////

module sys_hal_top import hal_pkg::*; (
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic              i_io_uio,
	input  logic              i_io_strobe,
	input  logic [DATA_W-1:0] i_io_din,
	input  logic              i_hs,
	input  logic              i_vs,
	output logic              o_io_ack,
	output logic              o_hs_fix,
	output logic              o_vs_fix,
	output logic              o_csync,
	output logic [DIM_W-1:0]  o_hmin,
	output logic [DIM_W-1:0]  o_hmax,
	output logic [DIM_W-1:0]  o_vmin,
	output logic [DIM_W-1:0]  o_vmax
);

	video_cfg_if u_cfg ();

	host_cmd_decoder u_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_io_ack    (o_io_ack),
		.cfg         (u_cfg.source)
	);

	video_window_calc u_window (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.cfg     (u_cfg.sink),
		.o_hmin  (o_hmin),
		.o_hmax  (o_hmax),
		.o_vmin  (o_vmin),
		.o_vmax  (o_vmax)
	);

	// Same normaliser for both sync directions
	sync_polarity_fix u_hs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (o_hs_fix)
	);

	sync_polarity_fix u_vs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (o_vs_fix)
	);

	csync_gen u_csync (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hs    (o_hs_fix),
		.i_vs    (o_vs_fix),
		.o_csync (o_csync)
	);

endmodule

/* test/tb_sys_hal.sv */
//////////////////////////////////////////////////
// Testbench for the host and video timing block
// File driven host commands, window and sync checks
//////////////////////////////////////////////////

module tb_sys_hal import hal_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          CLK_PERIOD  = 40;
	localparam int          DRIVE_DLY   = 5;
	localparam int          RESET_CYC   = 3;
	localparam int          SETTLE_CYC  = 200;
	localparam int          LINE_CYC    = 100;
	localparam int          HS_LEN      = 8;
	localparam int          FRAME_LINES = 10;
	localparam int          VS_LINES    = 2;
	localparam int          FRAME_CYC   = LINE_CYC * FRAME_LINES;
	localparam logic [31:0] SEED        = 32'h10df_271c;
	localparam string       STIM_FILE   = "test/video_stim.txt";

	logic              clk_sys;
	logic              resetd;
	logic              i_io_uio;
	logic              i_io_strobe;
	logic [DATA_W-1:0] i_io_din;
	logic              i_hs;
	logic              i_vs;
	logic              o_io_ack;
	logic              o_hs_fix;
	logic              o_vs_fix;
	logic              o_csync;
	logic [DIM_W-1:0]  o_hmin;
	logic [DIM_W-1:0]  o_hmax;
	logic [DIM_W-1:0]  o_vmin;
	logic [DIM_W-1:0]  o_vmax;

	logic [31:0] rnd_state;
	logic [7:0]  rec_kind[$];
	int          rec_vals[$];
	int          rec_total   = 0;
	int          win_err     = 0;
	int          ack_err     = 0;
	int          sync_err    = 0;
	int          words_sent  = 0;
	int          ack_rises   = 0;
	int          vs_hi_cnt   = 0;
	int          vs_lo_cnt   = 0;
	int          h_pos;
	int          v_pos;
	logic        sync_chk;
	logic        strobe_h1   = 1'b0;
	logic        strobe_h2   = 1'b0;
	logic        ack_prev    = 1'b0;
	logic        hs_prev     = 1'b0;
	logic        vs_prev     = 1'b0;

	sys_hal_top i_dut (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.i_hs        (i_hs),
		.i_vs        (i_vs),
		.o_io_ack    (o_io_ack),
		.o_hs_fix    (o_hs_fix),
		.o_vs_fix    (o_vs_fix),
		.o_csync     (o_csync),
		.o_hmin      (o_hmin),
		.o_hmax      (o_hmax),
		.o_vmin      (o_vmin),
		.o_vmax      (o_vmax)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic void report_mismatch(input string name, input int exp_val,
			input int act_val);
		$display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
	endfunction

	// Always lands just after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#DRIVE_DLY;
	endtask

	// Records go into queues, words follow their command
	task automatic load_stimulus(output bit ok);
		int                fd;
		int                code;
		int                n;
		int                v;
		logic [7:0]        kind;
		logic [8*128-1:0]  line;
		ok = 1'b0;
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %c", kind);
				if (code != 1)
					break;
				if (kind == "#") begin
					code = $fgets(line, fd);
				end else if (kind == "C") begin
					code = $fscanf(fd, "%h %d", v, n);
					rec_kind.push_back(kind);
					rec_vals.push_back(v);
					rec_vals.push_back(n);
					for (int i = 0; i < n; i++) begin
						code = $fscanf(fd, "%h", v);
						rec_vals.push_back(v);
					end
					rec_total++;
				end else if (kind == "E") begin
					rec_kind.push_back(kind);
					for (int i = 0; i < 4; i++) begin
						code = $fscanf(fd, "%d", v);
						rec_vals.push_back(v);
					end
					rec_total++;
				end
			end
			$fclose(fd);
			ok = (rec_total > 0);
		end
	endtask

	// Strobe low with data, then high, random extra low time
	task automatic send_word(input int w);
		rnd_state   = xorshift32(rnd_state);
		i_io_din    = DATA_W'(w);
		i_io_strobe = 1'b0;
		wait_cycles(2 + int'(rnd_state[1:0]));
		i_io_strobe = 1'b1;
		wait_cycles(2);
		i_io_strobe = 1'b0;
		words_sent++;
	endtask

	task automatic send_command;
		int cmd;
		int n;
		cmd      = rec_vals.pop_front();
		n        = rec_vals.pop_front();
		i_io_uio = 1'b1;
		wait_cycles(2);
		send_word(cmd);
		for (int i = 0; i < n; i++)
			send_word(rec_vals.pop_front());
		wait_cycles(2);
		i_io_uio = 1'b0;
		wait_cycles(3);
	endtask

	task automatic check_window;
		int    exp_v[4];
		int    act_v[4];
		string names[4];
		for (int i = 0; i < 4; i++)
			exp_v[i] = rec_vals.pop_front();
		wait_cycles(SETTLE_CYC);
		act_v = '{int'(o_hmin), int'(o_hmax), int'(o_vmin), int'(o_vmax)};
		names = '{"o_hmin", "o_hmax", "o_vmin", "o_vmax"};
		for (int i = 0; i < 4; i++) begin
			if (act_v[i] != exp_v[i]) begin
				report_mismatch(names[i], exp_v[i], act_v[i]);
				win_err++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Sync source, active low pulses

	initial begin
		h_pos = 0;
		v_pos = 0;
		i_hs  = 1'b1;
		i_vs  = 1'b1;
		forever begin
			@(posedge clk_sys);
			#DRIVE_DLY;
			i_hs = (h_pos >= HS_LEN);
			i_vs = (v_pos >= VS_LINES);
			if (h_pos == LINE_CYC - 1) begin
				h_pos = 0;
				v_pos = (v_pos == FRAME_LINES - 1) ? 0 : v_pos + 1;
			end else begin
				h_pos++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Monitors, sampled at the falling edge

	// Acknowledge is the strobe two cycles late
	always @(negedge clk_sys) begin
		if (!resetd) begin
			if (o_io_ack != strobe_h2) begin
				report_mismatch("o_io_ack", int'(strobe_h2), int'(o_io_ack));
				ack_err++;
			end
			if (o_io_ack && !ack_prev)
				ack_rises++;
		end
		ack_prev  = o_io_ack;
		strobe_h2 = strobe_h1;
		strobe_h1 = i_io_strobe;
	end

	// Csync registers hs and vs, so compare against last cycle
	always @(negedge clk_sys) begin
		if (sync_chk) begin
			if (o_hs_fix != !i_hs) begin
				report_mismatch("o_hs_fix", int'(!i_hs), int'(o_hs_fix));
				sync_err++;
			end
			if (o_vs_fix != !i_vs) begin
				report_mismatch("o_vs_fix", int'(!i_vs), int'(o_vs_fix));
				sync_err++;
			end
			if (!vs_prev && o_csync != hs_prev) begin
				report_mismatch("o_csync", int'(hs_prev), int'(o_csync));
				sync_err++;
			end
			if (vs_prev && hs_prev && !o_csync) begin
				report_mismatch("o_csync", 1, 0);
				sync_err++;
			end
			if (vs_prev && !hs_prev && o_csync)
				vs_hi_cnt++;
			if (vs_prev && !o_csync)
				vs_lo_cnt++;
		end
		hs_prev = o_hs_fix;
		vs_prev = o_vs_fix;
	end

	//////////////////////////////////////////////////
	// Watchdog

	initial begin
		wait (rec_total > 0);
		repeat (rec_total * 400 + 20000) @(posedge clk_sys);
		$display("Watchdog expired, the run took too long");
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		bit         loaded;
		logic [7:0] kind;
		i_io_uio    = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din    = '0;
		resetd      = 1'b1;
		sync_chk    = 1'b0;
		rnd_state   = SEED;
		load_stimulus(loaded);
		wait_cycles(RESET_CYC);
		resetd = 1'b0;
		wait_cycles(2);
		if (!loaded) begin
			$display("Stimulus file could not be read or holds no records");
			$display("TEST FAILED");
			$finish;
		end else begin
			while (rec_kind.size() > 0) begin
				kind = rec_kind.pop_front();
				if (kind == "C")
					send_command();
				else
					check_window();
			end
			// Let the polarity fixers settle over whole frames
			wait_cycles(2 * FRAME_CYC);
			sync_chk = 1'b1;
			wait_cycles(2 * FRAME_CYC);
			sync_chk = 1'b0;
			if (vs_hi_cnt == 0) begin
				$display("Csync never high while hsync was low during vsync");
				sync_err++;
			end
			if (vs_lo_cnt == 0) begin
				$display("Csync showed no pulses during vsync");
				sync_err++;
			end
			if (ack_rises != words_sent) begin
				report_mismatch("o_io_ack rising edges", words_sent, ack_rises);
				ack_err++;
			end
			$display("Errors: %0d total, window %0d, ack %0d, sync %0d",
				win_err + ack_err + sync_err, win_err, ack_err, sync_err);
			if (win_err + ack_err + sync_err == 0)
				$display("TEST OK");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

endmodule

/* test/video_stim.txt */
# C <opcode hex> <word count> <data words hex>   one host command, select dropped after
# E <hmin> <hmax> <vmin> <vmax>                  expected window in decimal
E 0 1919 0 1079
# 1280x720 frame, then 4:3 aspect
C 20 8 0500 006e 0028 00dc 02d0 0005 0005 0014
C 3a 2 0004 0003
E 160 1119 0 719
# Limits 1000 by 600 with free scale
C 37 1 83e8
C 27 1 0258
E 140 1139 60 659
# Free scale and horizontal limit cleared
C 37 1 0000
E 240 1039 60 659
# Timing cut short after two words, height stays 720
C 20 2 0400 0064
C 3a 2 0010 0009
E 0 1023 72 647

/* sim.f */
verilog/hal_pkg.sv
verilog/video_cfg_if.sv
verilog/host_cmd_decoder.sv
verilog/umuldiv.sv
verilog/video_window_calc.sv
verilog/sync_polarity_fix.sv
verilog/csync_gen.sv
verilog/sys_hal_top.sv
test/tb_sys_hal.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sys_hal
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
